//--- Bender.yml
package:
  name: trap_control_unit

dependencies: {}

sources:
  - source/core_types_pkg.sv
  - source/creg_pkg.sv
  - source/control_registers.sv
  - source/creg_access.sv
  - source/trap_sequencer.sv
  - source/trap_control_unit.sv
  - target: simulation
    files:
      - verif/trap_control_unit_assert.sv
      - verif/trap_control_unit_tb.sv

//--- project.f
source/core_types_pkg.sv
source/creg_pkg.sv
source/control_registers.sv
source/creg_access.sv
source/trap_sequencer.sv
source/trap_control_unit.sv
verif/trap_control_unit_assert.sv
verif/trap_control_unit_tb.sv

//--- source/control_registers.sv
`timescale 1ns/1ps

module control_registers
#(
    parameter int NUM_THREADS = 4,
    parameter int CORE_ID = 0
)
(
    input  logic                          clk,
    input  logic                          reset,

    // Register access strobes
    input  logic                          creg_write_en,
    input  logic                          creg_read_en,
    input  core_types_pkg::thread_idx_t   creg_thread,
    input  creg_pkg::creg_index_t         creg_index,
    input  creg_pkg::creg_word_u          creg_write_val,
    output creg_pkg::creg_word_u          creg_read_val,

    // Trap stack commands
    input  logic                          trap_en,
    input  logic                          eret_en,
    input  core_types_pkg::trap_event_t   evt,

    output core_types_pkg::scalar_t       trap_handler,
    output core_types_pkg::scalar_t       tlb_miss_handler,
    output core_types_pkg::scalar_t       eret_address[NUM_THREADS],
    output core_types_pkg::subcycle_t     eret_subcycle[NUM_THREADS],
    output core_types_pkg::thread_status_t status[NUM_THREADS]
);

    import core_types_pkg::*;
    import creg_pkg::*;

    // One level of the trap stack for one thread
    typedef struct packed
    {
        scalar_t eret_address;
        trap_reason_t reason;
        scalar_t access_addr;
        subcycle_t subcycle;
        logic supervisor_en;
        logic mmu_en;
        logic interrupt_en;
    } trap_frame_t;

    trap_frame_t frame[2][NUM_THREADS];
    scalar_t scratchpad0[NUM_THREADS];
    scalar_t scratchpad1[NUM_THREADS];
    scalar_t page_dir_base[NUM_THREADS];
    scalar_t cycle_count;
    scalar_t cycle_count_next;
    creg_word_u read_word;
    trap_frame_t new_frame;

    assign cycle_count_next = cycle_count + 1;

    always_comb
    begin
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            eret_address[t] = frame[0][t].eret_address;
            eret_subcycle[t] = frame[0][t].subcycle;
        end
    end

    // Frame pushed on a trap, carrying the thread's flags from before it
    always_comb
    begin
        new_frame.eret_address = evt.pc;
        new_frame.reason = evt.reason;
        new_frame.access_addr = evt.access_addr;
        new_frame.subcycle = evt.subcycle;
        new_frame.supervisor_en = status[evt.thread].supervisor_en;
        new_frame.mmu_en = status[evt.thread].mmu_en;
        new_frame.interrupt_en = status[evt.thread].interrupt_en;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int t = 0; t < NUM_THREADS; t++)
            begin
                for (int level = 0; level < 2; level++)
                begin
                    frame[level][t] <= '0;
                    frame[level][t].reason <= TR_RESET;
                end
                status[t].supervisor_en <= 1'b1;
                status[t].mmu_en <= 1'b0;
                status[t].interrupt_en <= 1'b0;
                status[t].asid <= '0;
                scratchpad0[t] <= '0;
                scratchpad1[t] <= '0;
                page_dir_base[t] <= '0;
            end
            trap_handler <= '0;
            tlb_miss_handler <= '0;
            cycle_count <= '0;
        end
        else
        begin
            cycle_count <= cycle_count_next;

            if (trap_en)
            begin
                frame[1][evt.thread] <= frame[0][evt.thread];
                frame[0][evt.thread] <= new_frame;
                status[evt.thread].supervisor_en <= 1'b1;
                status[evt.thread].interrupt_en <= 1'b0;
                if (evt.reason == TR_ITLB_MISS || evt.reason == TR_DTLB_MISS)
                    status[evt.thread].mmu_en <= 1'b0;
            end
            else if (eret_en)
            begin
                status[evt.thread].supervisor_en <= frame[0][evt.thread].supervisor_en;
                status[evt.thread].mmu_en <= frame[0][evt.thread].mmu_en;
                status[evt.thread].interrupt_en <= frame[0][evt.thread].interrupt_en;
                frame[0][evt.thread] <= frame[1][evt.thread];
            end

            // Comes after the event so a write to the same register wins
            if (creg_write_en)
            begin
                case (creg_index)
                    CR_FLAGS:
                    begin
                        status[creg_thread].supervisor_en <= creg_write_val.flags.supervisor_en;
                        status[creg_thread].mmu_en <= creg_write_val.flags.mmu_en;
                        status[creg_thread].interrupt_en <= creg_write_val.flags.interrupt_en;
                    end

                    CR_SAVED_FLAGS:
                    begin
                        frame[0][creg_thread].supervisor_en <= creg_write_val.flags.supervisor_en;
                        frame[0][creg_thread].mmu_en <= creg_write_val.flags.mmu_en;
                        frame[0][creg_thread].interrupt_en <= creg_write_val.flags.interrupt_en;
                    end

                    CR_TRAP_PC:
                        frame[0][creg_thread].eret_address <= creg_write_val.value;
                    CR_TRAP_HANDLER:
                        trap_handler <= creg_write_val.value;
                    CR_TLB_MISS_HANDLER:
                        tlb_miss_handler <= creg_write_val.value;
                    CR_SCRATCHPAD0:
                        scratchpad0[creg_thread] <= creg_write_val.value;
                    CR_SCRATCHPAD1:
                        scratchpad1[creg_thread] <= creg_write_val.value;
                    CR_SUBCYCLE:
                        frame[0][creg_thread].subcycle <= subcycle_t'(creg_write_val.value);
                    CR_CURRENT_ASID:
                        status[creg_thread].asid <= creg_write_val.value[ASID_WIDTH - 1:0];
                    CR_PAGE_DIR:
                        page_dir_base[creg_thread] <= creg_write_val.value;
                    default:
                        ;
                endcase
            end
        end
    end

    // Read mux, decoded through the union
    always_comb
    begin
        read_word = '0;
        case (creg_index)
            CR_FLAGS:
            begin
                read_word.flags.supervisor_en = status[creg_thread].supervisor_en;
                read_word.flags.mmu_en = status[creg_thread].mmu_en;
                read_word.flags.interrupt_en = status[creg_thread].interrupt_en;
            end

            CR_SAVED_FLAGS:
            begin
                read_word.flags.supervisor_en = frame[0][creg_thread].supervisor_en;
                read_word.flags.mmu_en = frame[0][creg_thread].mmu_en;
                read_word.flags.interrupt_en = frame[0][creg_thread].interrupt_en;
            end

            CR_THREAD_ID:
                read_word.value = (scalar_t'(CORE_ID) << $bits(thread_idx_t))
                    | scalar_t'(creg_thread);
            CR_TRAP_PC:          read_word.value = frame[0][creg_thread].eret_address;
            CR_TRAP_REASON:      read_word.value = scalar_t'(frame[0][creg_thread].reason);
            CR_TRAP_HANDLER:     read_word.value = trap_handler;
            CR_TRAP_ADDRESS:     read_word.value = frame[0][creg_thread].access_addr;
            CR_TLB_MISS_HANDLER: read_word.value = tlb_miss_handler;
            // Value the counter takes at this same edge
            CR_CYCLE_COUNT:      read_word.value = cycle_count_next;
            CR_SCRATCHPAD0:      read_word.value = scratchpad0[creg_thread];
            CR_SCRATCHPAD1:      read_word.value = scratchpad1[creg_thread];
            CR_SUBCYCLE:         read_word.value = scalar_t'(frame[0][creg_thread].subcycle);
            CR_CURRENT_ASID:     read_word.value = scalar_t'(status[creg_thread].asid);
            CR_PAGE_DIR:         read_word.value = page_dir_base[creg_thread];
            default:             read_word.value = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (creg_read_en)
            creg_read_val <= read_word;
    end

endmodule

//--- source/core_types_pkg.sv
package core_types_pkg;

    localparam int ASID_WIDTH = 8;

    typedef logic [31:0] scalar_t;
    typedef logic [1:0] thread_idx_t;

    // Element index where a vector operation picks up again
    typedef logic [3:0] subcycle_t;

    typedef enum logic [3:0]
    {
        TR_RESET            = 4'd0,
        TR_ILLEGAL_INST     = 4'd1,
        TR_PRIVILEGED_OP    = 4'd2,
        TR_INTERRUPT        = 4'd3,
        TR_ITLB_MISS        = 4'd4,
        TR_DTLB_MISS        = 4'd5,
        TR_PAGE_FAULT       = 4'd6,
        TR_SYSCALL          = 4'd7,
        TR_BREAKPOINT       = 4'd8
    } trap_reason_t;

    // Offered on the event port, a trap or a return from trap
    typedef struct packed
    {
        logic is_eret;
        thread_idx_t thread;
        trap_reason_t reason;
        scalar_t pc;
        scalar_t access_addr;
        subcycle_t subcycle;
    } trap_event_t;

    // Where fetch resumes for a thread
    typedef struct packed
    {
        thread_idx_t thread;
        scalar_t pc;
        subcycle_t subcycle;
    } redirect_t;

    typedef struct packed
    {
        logic supervisor_en;
        logic mmu_en;
        logic interrupt_en;
        logic [ASID_WIDTH - 1:0] asid;
    } thread_status_t;

endpackage

//--- source/creg_access.sv
`timescale 1ns/1ps

module creg_access
(
    input  logic                        clk,
    input  logic                        reset,

    // Access request port
    input  logic                        req_valid,
    output logic                        req_ready,
    input  creg_pkg::creg_req_t         req,

    // Read response port
    output logic                        resp_valid,
    input  logic                        resp_ready,
    output creg_pkg::creg_resp_t        resp,

    // To and from the register block
    output logic                        creg_write_en,
    output logic                        creg_read_en,
    output core_types_pkg::thread_idx_t creg_thread,
    output creg_pkg::creg_index_t       creg_index,
    output creg_pkg::creg_word_u        creg_write_val,
    input  creg_pkg::creg_word_u        creg_read_val
);

    logic req_accept;

    // A pending response blocks new requests only while it is not taken
    assign req_ready = !resp_valid || resp_ready;
    assign req_accept = req_valid && req_ready;

    assign creg_write_en = req_accept && req.write;
    assign creg_read_en = req_accept && !req.write;
    assign creg_thread = req.thread;
    assign creg_index = req.index;
    assign creg_write_val = req.data;

    // Read data register only loads on an accepted read, so it holds
    assign resp.data = creg_read_val;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            resp_valid <= 1'b0;
        else if (creg_read_en)
            resp_valid <= 1'b1;
        else if (resp_ready)
            resp_valid <= 1'b0;
    end

endmodule

//--- source/creg_pkg.sv
package creg_pkg;

    import core_types_pkg::*;

    typedef enum logic [4:0]
    {
        CR_FLAGS            = 5'd0,
        CR_SAVED_FLAGS      = 5'd1,
        CR_THREAD_ID        = 5'd2,
        CR_TRAP_PC          = 5'd3,
        CR_TRAP_REASON      = 5'd4,
        CR_TRAP_HANDLER     = 5'd5,
        CR_TRAP_ADDRESS     = 5'd6,
        CR_TLB_MISS_HANDLER = 5'd7,
        CR_CYCLE_COUNT      = 5'd8,
        CR_SCRATCHPAD0      = 5'd9,
        CR_SCRATCHPAD1      = 5'd10,
        CR_SUBCYCLE         = 5'd11,
        CR_CURRENT_ASID     = 5'd12,
        CR_PAGE_DIR         = 5'd13
    } creg_index_t;

    typedef struct packed
    {
        logic [28:0] reserved;
        logic supervisor_en;
        logic mmu_en;
        logic interrupt_en;
    } creg_flags_t;

    // Flags and saved flags use the triple view, everything else the scalar
    typedef union packed
    {
        scalar_t value;
        creg_flags_t flags;
    } creg_word_u;

    typedef struct packed
    {
        thread_idx_t thread;
        logic write;
        creg_index_t index;
        creg_word_u data;
    } creg_req_t;

    typedef struct packed
    {
        creg_word_u data;
    } creg_resp_t;

endpackage

//--- source/trap_control_unit.sv
`timescale 1ns/1ps

module trap_control_unit
#(
    parameter int NUM_THREADS = 4,
    parameter int CORE_ID = 0
)
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           req_valid,
    output logic                           req_ready,
    input  creg_pkg::creg_req_t            req,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output creg_pkg::creg_resp_t           resp,

    input  logic                           event_valid,
    output logic                           event_ready,
    input  core_types_pkg::trap_event_t    trap_event,

    output logic                           redirect_valid,
    input  logic                           redirect_ready,
    output core_types_pkg::redirect_t      redirect,

    output core_types_pkg::thread_status_t status[NUM_THREADS]
);

    import core_types_pkg::*;
    import creg_pkg::*;

    logic creg_write_en;
    logic creg_read_en;
    thread_idx_t creg_thread;
    creg_index_t creg_index;
    creg_word_u creg_write_val;
    creg_word_u creg_read_val;
    logic trap_en;
    logic eret_en;
    trap_event_t evt;
    scalar_t trap_handler;
    scalar_t tlb_miss_handler;
    scalar_t eret_address[NUM_THREADS];
    subcycle_t eret_subcycle[NUM_THREADS];

    control_registers #(
        .NUM_THREADS(NUM_THREADS),
        .CORE_ID(CORE_ID)
    ) i_control_registers (.*);

    creg_access i_creg_access (.*);

    trap_sequencer #(
        .NUM_THREADS(NUM_THREADS)
    ) i_trap_sequencer (.*);

endmodule

//--- source/trap_sequencer.sv
`timescale 1ns/1ps

module trap_sequencer
#(
    parameter int NUM_THREADS = 4
)
(
    input  logic                          clk,
    input  logic                          reset,

    // Event port
    input  logic                          event_valid,
    output logic                          event_ready,
    input  core_types_pkg::trap_event_t   trap_event,

    // Trap stack commands
    output logic                          trap_en,
    output logic                          eret_en,
    output core_types_pkg::trap_event_t   evt,

    // Resume targets from the register block
    input  core_types_pkg::scalar_t       trap_handler,
    input  core_types_pkg::scalar_t       tlb_miss_handler,
    input  core_types_pkg::scalar_t       eret_address[NUM_THREADS],
    input  core_types_pkg::subcycle_t     eret_subcycle[NUM_THREADS],

    // Redirect port
    output logic                          redirect_valid,
    input  logic                          redirect_ready,
    output core_types_pkg::redirect_t     redirect
);

    import core_types_pkg::*;

    logic event_accept;
    redirect_t next_redirect;

    assign event_ready = !redirect_valid || redirect_ready;
    assign event_accept = event_valid && event_ready;

    assign trap_en = event_accept && !trap_event.is_eret;
    assign eret_en = event_accept && trap_event.is_eret;
    assign evt = trap_event;

    // Built from stack contents before the event updates them
    always_comb
    begin
        next_redirect.thread = trap_event.thread;
        if (trap_event.is_eret)
        begin
            next_redirect.pc = eret_address[trap_event.thread];
            next_redirect.subcycle = eret_subcycle[trap_event.thread];
        end
        else
        begin
            if (trap_event.reason == TR_ITLB_MISS || trap_event.reason == TR_DTLB_MISS)
                next_redirect.pc = tlb_miss_handler;
            else
                next_redirect.pc = trap_handler;
            next_redirect.subcycle = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (event_accept)
            redirect <= next_redirect;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            redirect_valid <= 1'b0;
        else if (event_accept)
            redirect_valid <= 1'b1;
        else if (redirect_ready)
            redirect_valid <= 1'b0;
    end

endmodule

//--- verif/trap_control_unit_assert.sv
`timescale 1ns/1ps

module trap_control_unit_assert
(
    input logic                      clk,
    input logic                      reset,
    input logic                      creg_write_en,
    input logic                      creg_read_en,
    input logic                      trap_en,
    input logic                      eret_en,
    input logic                      resp_valid,
    input logic                      resp_ready,
    input creg_pkg::creg_resp_t      resp,
    input logic                      redirect_valid,
    input logic                      redirect_ready,
    input core_types_pkg::redirect_t redirect
);

    // Only reads raise a response
    assert property (@(posedge clk) disable iff (reset) creg_read_en |=> resp_valid)
        else $error("Accepted read gave no response");

    assert property (@(posedge clk) disable iff (reset)
        creg_write_en && !resp_valid |=> !resp_valid)
        else $error("Accepted write gave a response");

    assert property (@(posedge clk) disable iff (reset) trap_en || eret_en |=> redirect_valid)
        else $error("Accepted event gave no redirect");

    // Held outputs under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("Response changed or dropped while not taken");

    assert property (@(posedge clk) disable iff (reset)
        redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect))
        else $error("Redirect changed or dropped while not taken");

endmodule

bind trap_control_unit trap_control_unit_assert i_trap_control_unit_assert (.*);

//--- verif/trap_control_unit_tb.sv
`timescale 1ns/1ps

module trap_control_unit_tb;

    import core_types_pkg::*;
    import creg_pkg::*;

    localparam int NUM_THREADS = 4;
    localparam int CORE_ID = 3;
    localparam int NUM_TRANSFERS = 2000;
    // About one transfer per cycle over both ports plus reset and drain
    localparam int MAX_CYCLES = 3000;

    typedef struct packed
    {
        scalar_t pc;
        scalar_t addr;
        trap_reason_t reason;
        subcycle_t sub;
        logic [2:0] flags;
    } frame_t;

    logic clk;
    logic reset;
    logic req_valid;
    logic req_ready;
    creg_req_t req;
    logic resp_valid;
    logic resp_ready;
    creg_resp_t resp;
    logic event_valid;
    logic event_ready;
    trap_event_t trap_event;
    logic redirect_valid;
    logic redirect_ready;
    redirect_t redirect;
    thread_status_t status[NUM_THREADS];

    // Reference model state
    thread_status_t m_status[NUM_THREADS];
    frame_t m_frame[2][NUM_THREADS];
    scalar_t m_scratch0[NUM_THREADS];
    scalar_t m_scratch1[NUM_THREADS];
    scalar_t m_page_dir[NUM_THREADS];
    scalar_t m_handler;
    scalar_t m_tlb_handler;

    scalar_t exp_resp[$];
    logic exp_is_cycle[$];
    redirect_t exp_redirect[$];

    logic [31:0] lfsr_state;
    int clk_count;
    int cycle_total;
    int transfers;
    int value_errors;
    int other_errors;
    scalar_t last_cycle;
    logic req_fire;
    logic evt_fire;

    trap_control_unit #(
        .NUM_THREADS(NUM_THREADS),
        .CORE_ID(CORE_ID)
    ) i_trap_control_unit (.*);

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_total++;
        if (cycle_total >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d transfers done", cycle_total, transfers);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Galois LFSR with one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic scalar_t expected_read(input thread_idx_t t, input creg_index_t index);
        case (index)
            CR_FLAGS:
                return {29'b0, m_status[t].supervisor_en, m_status[t].mmu_en,
                    m_status[t].interrupt_en};
            CR_SAVED_FLAGS:      return {29'b0, m_frame[0][t].flags};
            CR_THREAD_ID:        return scalar_t'(CORE_ID * 4 + t);
            CR_TRAP_PC:          return m_frame[0][t].pc;
            CR_TRAP_REASON:      return scalar_t'(m_frame[0][t].reason);
            CR_TRAP_HANDLER:     return m_handler;
            CR_TRAP_ADDRESS:     return m_frame[0][t].addr;
            CR_TLB_MISS_HANDLER: return m_tlb_handler;
            // Clocks since reset including the acceptance edge
            CR_CYCLE_COUNT:      return scalar_t'(clk_count + 1);
            CR_SCRATCHPAD0:      return m_scratch0[t];
            CR_SCRATCHPAD1:      return m_scratch1[t];
            CR_SUBCYCLE:         return scalar_t'(m_frame[0][t].sub);
            CR_CURRENT_ASID:     return scalar_t'(m_status[t].asid);
            CR_PAGE_DIR:         return m_page_dir[t];
            default:             return 32'hffff_ffff;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
        input logic [63:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name,
                expected, actual);
        end
    endtask

    // Valid and payload hold until accepted
    task automatic drive_inputs();
        if (!req_valid || req_fire)
        begin
            req_valid = (transfers < NUM_TRANSFERS) && (random_bits(2) != 0);
            req.thread = thread_idx_t'(random_bits(2));
            // Reads only at first so reset values are seen
            req.write = (transfers > 100) && random_bits(1);
            req.index = creg_index_t'(5'(random_bits(4)));
            req.data.value = random_bits(32);
        end
        if (!event_valid || evt_fire)
        begin
            event_valid = (transfers < NUM_TRANSFERS) && (random_bits(2) != 0);
            trap_event.is_eret = random_bits(1);
            trap_event.thread = thread_idx_t'(random_bits(2));
            trap_event.reason = trap_reason_t'(4'(random_bits(4) % 9));
            trap_event.pc = random_bits(32);
            trap_event.access_addr = random_bits(32);
            trap_event.subcycle = subcycle_t'(random_bits(4));
        end
        resp_ready = random_bits(1);
        redirect_ready = random_bits(1);
    endtask

    // Mid-cycle output checks, then the coming edge applied to the model
    task automatic check_cycle();
        trap_event_t e;
        creg_req_t r;
        redirect_t rd;
        scalar_t d;
        e = trap_event;
        r = req;
        d = r.data.value;
        for (int t = 0; t < NUM_THREADS; t++)
            compare_value($sformatf("status[%0d]", t), 64'(m_status[t]), 64'(status[t]));

        // Outstanding responses and redirects decide valid and ready
        compare_value("resp_valid", 64'(exp_resp.size() != 0), 64'(resp_valid));
        compare_value("req_ready", 64'(exp_resp.size() == 0 || resp_ready), 64'(req_ready));
        compare_value("redirect_valid", 64'(exp_redirect.size() != 0), 64'(redirect_valid));
        compare_value("event_ready", 64'(exp_redirect.size() == 0 || redirect_ready),
            64'(event_ready));

        if (resp_valid && resp_ready)
        begin
            if (exp_resp.size() == 0)
            begin
                other_errors++;
                $display("Response taken at %0t with no read outstanding", $time);
            end
            else
            begin
                compare_value("resp.data", 64'(exp_resp.pop_front()), 64'(resp.data.value));
                if (exp_is_cycle.pop_front())
                begin
                    if (resp.data.value <= last_cycle || resp.data.value > scalar_t'(clk_count))
                    begin
                        other_errors++;
                        $display("Cycle count %0d at %0t not above %0d or beyond %0d clocks",
                            resp.data.value, $time, last_cycle, clk_count);
                    end
                    last_cycle = resp.data.value;
                end
            end
        end

        if (redirect_valid && redirect_ready)
        begin
            if (exp_redirect.size() == 0)
            begin
                other_errors++;
                $display("Redirect taken at %0t with no event outstanding", $time);
            end
            else
                compare_value("redirect", 64'(exp_redirect.pop_front()), 64'(redirect));
        end

        req_fire = req_valid && req_ready;
        evt_fire = event_valid && event_ready;

        // Reads see the registers from before this edge's event
        if (req_fire && !r.write)
        begin
            exp_resp.push_back(expected_read(r.thread, r.index));
            exp_is_cycle.push_back(r.index == CR_CYCLE_COUNT);
        end

        if (evt_fire)
        begin
            transfers++;
            rd.thread = e.thread;
            if (e.is_eret)
            begin
                rd.pc = m_frame[0][e.thread].pc;
                rd.subcycle = m_frame[0][e.thread].sub;
                {m_status[e.thread].supervisor_en, m_status[e.thread].mmu_en,
                    m_status[e.thread].interrupt_en} = m_frame[0][e.thread].flags;
                m_frame[0][e.thread] = m_frame[1][e.thread];
            end
            else
            begin
                rd.pc = (e.reason == TR_ITLB_MISS || e.reason == TR_DTLB_MISS)
                    ? m_tlb_handler : m_handler;
                rd.subcycle = '0;
                m_frame[1][e.thread] = m_frame[0][e.thread];
                m_frame[0][e.thread] = {e.pc, e.access_addr, e.reason, e.subcycle,
                    m_status[e.thread].supervisor_en, m_status[e.thread].mmu_en,
                    m_status[e.thread].interrupt_en};
                m_status[e.thread].supervisor_en = 1'b1;
                m_status[e.thread].interrupt_en = 1'b0;
                if (e.reason == TR_ITLB_MISS || e.reason == TR_DTLB_MISS)
                    m_status[e.thread].mmu_en = 1'b0;
            end
            exp_redirect.push_back(rd);
        end

        if (req_fire)
        begin
            transfers++;
            if (r.write)
            begin
                // Applied after the event so the write wins
                case (r.index)
                    CR_FLAGS:
                        {m_status[r.thread].supervisor_en, m_status[r.thread].mmu_en,
                            m_status[r.thread].interrupt_en} = d[2:0];
                    CR_SAVED_FLAGS:      m_frame[0][r.thread].flags = d[2:0];
                    CR_TRAP_PC:          m_frame[0][r.thread].pc = d;
                    CR_TRAP_HANDLER:     m_handler = d;
                    CR_TLB_MISS_HANDLER: m_tlb_handler = d;
                    CR_SCRATCHPAD0:      m_scratch0[r.thread] = d;
                    CR_SCRATCHPAD1:      m_scratch1[r.thread] = d;
                    CR_SUBCYCLE:         m_frame[0][r.thread].sub = d[3:0];
                    CR_CURRENT_ASID:     m_status[r.thread].asid = d[7:0];
                    CR_PAGE_DIR:         m_page_dir[r.thread] = d;
                    default:             ;
                endcase
            end
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        event_valid = 1'b0;
        trap_event = '0;
        redirect_ready = 1'b0;
        lfsr_state = 32'hb5b6_52a4;
        clk_count = 0;
        cycle_total = 0;
        transfers = 0;
        value_errors = 0;
        other_errors = 0;
        last_cycle = '0;
        req_fire = 1'b0;
        evt_fire = 1'b0;
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            m_status[t] = '0;
            m_status[t].supervisor_en = 1'b1;
            m_frame[0][t] = '0;
            m_frame[1][t] = '0;
            m_scratch0[t] = '0;
            m_scratch1[t] = '0;
            m_page_dir[t] = '0;
        end
        m_handler = '0;
        m_tlb_handler = '0;

        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b0;

        while (transfers < NUM_TRANSFERS || req_valid || event_valid
            || exp_resp.size() != 0 || exp_redirect.size() != 0)
        begin
            drive_inputs();
            #1;
            check_cycle();
            @(posedge clk);
            clk_count++;
            #0.5;
        end

        if (resp_valid || redirect_valid)
        begin
            other_errors++;
            $display("Output still valid after all expected transfers were taken");
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
